/* ctrlUnit.f */
hdl/cpuPkg.sv
hdl/phaseSequencer.sv
hdl/aluGroupDecoder.sv
hdl/ldsGroupDecoder.sv
hdl/jmpGroupDecoder.sv
hdl/opxMultiplexer.sv
hdl/ctrlUnit.sv
test/ctrlUnit_assert.sv
test/ctrlChecker.sv
test/ctrlUnitTb.sv

/* Bender.yml */
package:
  name: ctrlunit

sources:
  - files:
      - hdl/cpuPkg.sv
      - hdl/phaseSequencer.sv
      - hdl/aluGroupDecoder.sv
      - hdl/ldsGroupDecoder.sv
      - hdl/jmpGroupDecoder.sv
      - hdl/opxMultiplexer.sv
      - hdl/ctrlUnit.sv
  - target: test
    files:
      - test/ctrlUnit_assert.sv
      - test/ctrlChecker.sv
      - test/ctrlUnitTb.sv

/* test/ctrlUnitTb.sv */
module ctrlUnitTb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int NumInstr    = 400;
	localparam int ClkPeriod   = 10;
	localparam int ResetCycles = 2;
	localparam int RunCycles   = NumInstr * 4;
	localparam int TimeoutNs   = (RunCycles + ResetCycles + 50) * ClkPeriod;   // run plus margin.

	logic              CLK;
	logic              rstN;
	cpuPkg::instrWord  fetchWord;
	cpuPkg::cpuPhase   phase;
	cpuPkg::ctrlBundle ctrl;
	cpuPkg::addrBusSel addrSel;
	int                errorCount;
	int                checkCount;
	integer            seed;

	ctrlUnit ctrlUnit_inst (
		.CLK       (CLK),
		.rstN      (rstN),
		.fetchWord (fetchWord),
		.phase     (phase),
		.ctrl      (ctrl),
		.addrSel   (addrSel)
	);

	ctrlChecker ctrlChecker_inst (
		.CLK        (CLK),
		.rstN       (rstN),
		.fetchWord  (fetchWord),
		.phase      (phase),
		.ctrl       (ctrl),
		.addrSel    (addrSel),
		.errorCount (errorCount),
		.checkCount (checkCount)
	);

	initial begin
		CLK = 1'b0;
		forever #(ClkPeriod / 2) CLK = ~CLK;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stimulus
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	initial begin : stimulus
		cpuPkg::instrWord word;
		int               assertFails;
		rstN      = 1'b0;
		fetchWord = '0;
		seed      = 44269;
		repeat (ResetCycles) @(posedge CLK);
		rstN <= 1'b1;
		for (int cyc = 0; cyc < RunCycles; cyc++) begin
			word        = $random(seed);
			word[15:14] = 2'(cyc >> 2);   // walks all four groups.
			fetchWord   <= word;
			@(posedge CLK);
		end
		repeat (3) @(posedge CLK);
		assertFails = ctrlUnit_inst.ctrlUnit_assert_inst.failCount;
		$display("checks %0d, errors %0d, assertion failures %0d", checkCount, errorCount,
			assertFails);
		if (errorCount == 0 && assertFails == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

	initial begin : watchdog
		#(TimeoutNs);
		$display("timeout: run did not end within %0d ns", TimeoutNs);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

/* test/ctrlChecker.sv */
module ctrlChecker (
	input  logic              CLK,
	input  logic              rstN,
	input  cpuPkg::instrWord  fetchWord,
	input  cpuPkg::cpuPhase   phase,
	input  cpuPkg::ctrlBundle ctrl,
	input  cpuPkg::addrBusSel addrSel,
	output int                errorCount,
	output int                checkCount
);
	timeunit 1ns;
	timeprecision 1ps;

	cpuPkg::cpuPhase   modelPhase;
	cpuPkg::instrWord  modelInstr;
	cpuPkg::addrBusSel modelAddrSel;
	logic              modelValid;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// reference model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic cpuPkg::ctrlBundle expectedCtrl(cpuPkg::cpuPhase ph, cpuPkg::instrWord iw);
		cpuPkg::ctrlBundle want;
		logic              midPhase;
		want     = cpuPkg::NopBundle;
		midPhase = (ph == cpuPkg::PhaseDecode) || (ph == cpuPkg::PhaseExecute);
		case (iw[15:14])
			cpuPkg::GroupAluLogic: begin
				want.aluOp    = iw[13:10];
				want.aluBSrc  = iw[4] ? cpuPkg::AluBSrcImm : cpuPkg::AluBSrcRegB;
				want.regAEn   = midPhase;
				want.regAWen  = (ph == cpuPkg::PhaseCommit);
				want.regAAddr = iw[9:8];
				want.regBEn   = midPhase;
				want.regBAddr = iw[7:5];
			end
			cpuPkg::GroupLoadStore: begin
				want.aluOp    = cpuPkg::AluOpMovB;   // address is base register B.
				want.regAEn   = midPhase;
				want.regAAddr = iw[11:10];
				want.regBEn   = midPhase;
				want.regBAddr = iw[9:7];
				want.byteMode = iw[12];
				if (iw[12]) begin
					want.regAByteEn = cpuPkg::ByteEnLow;
				end
				if (iw[13]) begin
					want.dataBus = cpuPkg::DataBusRegA;
					want.wr      = (ph == cpuPkg::PhaseExecute);
				end else begin
					want.dataBus = cpuPkg::DataBusMem;
					want.regADin = cpuPkg::RegADinDataBus;
					want.regAWen = (ph == cpuPkg::PhaseCommit);
					want.rd      = (ph == cpuPkg::PhaseExecute);
				end
			end
			cpuPkg::GroupJump: begin
				want.aluBSrc  = iw[13] ? cpuPkg::AluBSrcRegB : cpuPkg::AluBSrcImm;
				want.regBAddr = iw[12:10];
				want.regBEn   = midPhase;
			end
			default: ;
		endcase
		return want;
	endfunction

	function automatic cpuPkg::addrBusSel groupAddrSel(cpuPkg::instrGroup grp);
		return (grp == cpuPkg::GroupLoadStore) ? cpuPkg::AddrBusAluR : cpuPkg::AddrBusPc;
	endfunction

	function automatic string testNameFor(cpuPkg::instrWord iw);
		case (iw[15:14])
			cpuPkg::GroupAluLogic:  return "aluLogic";
			cpuPkg::GroupLoadStore: return iw[13] ? "store" : "load";
			cpuPkg::GroupJump:      return "jump";
			default:                return "system";
		endcase
	endfunction

	task automatic compareValue(input string testName,
			input logic [$bits(cpuPkg::ctrlBundle)-1:0] expected,
			input logic [$bits(cpuPkg::ctrlBundle)-1:0] actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("mismatch %s: expected %h, actual %h at %0t", testName, expected, actual,
				$time);
		end
	endtask

	initial begin
		errorCount = 0;
		checkCount = 0;
		modelValid = 1'b0;
	end

	// outputs are stable at the falling edge.
	always @(negedge CLK) begin
		if (!rstN) begin
			modelPhase   = cpuPkg::PhaseFetch;   // state after the next edge.
			modelInstr   = '0;
			modelAddrSel = cpuPkg::AddrBusPc;
			modelValid   = 1'b1;
		end else if (modelValid) begin
			compareValue("phase", modelPhase, phase);
			compareValue(testNameFor(modelInstr), expectedCtrl(modelPhase, modelInstr), ctrl);
			compareValue("addrSel", modelAddrSel, addrSel);
			if (modelPhase == cpuPkg::PhaseFetch) begin
				modelAddrSel = cpuPkg::AddrBusPc;
				modelInstr   = fetchWord;
			end else begin
				modelAddrSel = groupAddrSel(modelInstr[15:14]);
			end
			modelPhase = (modelPhase == cpuPkg::PhaseCommit) ? cpuPkg::PhaseFetch :
				cpuPkg::cpuPhase'(modelPhase + 2'd1);
		end
	end

endmodule

/* test/ctrlUnit_assert.sv */
module ctrlUnit_assert (
	input logic              CLK,
	input logic              rstN,
	input cpuPkg::cpuPhase   phase,
	input cpuPkg::ctrlBundle ctrl
);
	timeunit 1ns;
	timeprecision 1ps;

	int failCount = 0;

	// one step per clock, wrapping after commit.
	phaseOrder: assert property (@(posedge CLK) disable iff (!rstN)
		rstN |=> (2'(phase) == 2'($past(phase)) + 2'd1))
		else begin
			$error("phase did not advance by one step");
			failCount++;
		end

	strobeInExecute: assert property (@(posedge CLK) disable iff (!rstN)
		(ctrl.rd || ctrl.wr) |-> (phase == cpuPkg::PhaseExecute))
		else begin
			$error("memory strobe outside execute");
			failCount++;
		end

	writeInCommit: assert property (@(posedge CLK) disable iff (!rstN)
		(ctrl.regAWen || ctrl.regBWen) |-> (phase == cpuPkg::PhaseCommit))
		else begin
			$error("register write enable outside commit");
			failCount++;
		end

endmodule

bind ctrlUnit ctrlUnit_assert ctrlUnit_assert_inst (
	.CLK   (CLK),
	.rstN  (rstN),
	.phase (phase),
	.ctrl  (ctrl)
);

/* hdl/ctrlUnit.sv */
module ctrlUnit (
	input  logic              CLK,
	input  logic              rstN,
	input  cpuPkg::instrWord  fetchWord,
	output cpuPkg::cpuPhase   phase,
	output cpuPkg::ctrlBundle ctrl,
	output cpuPkg::addrBusSel addrSel
);

	cpuPkg::instrWord  instr;
	cpuPkg::ctrlBundle aluBundle;
	cpuPkg::ctrlBundle ldsBundle;
	cpuPkg::ctrlBundle jmpBundle;
	cpuPkg::addrBusSel aluAddrSel;
	cpuPkg::addrBusSel ldsAddrSel;

	phaseSequencer phaseSequencer_inst (
		.CLK       (CLK),
		.rstN      (rstN),
		.fetchWord (fetchWord),
		.phase     (phase),
		.instr     (instr)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// group decoders
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	aluGroupDecoder aluGroupDecoder_inst (
		.phase   (phase),
		.instr   (instr),
		.bundle  (aluBundle),
		.addrSel (aluAddrSel)
	);

	ldsGroupDecoder ldsGroupDecoder_inst (
		.phase   (phase),
		.instr   (instr),
		.bundle  (ldsBundle),
		.addrSel (ldsAddrSel)
	);

	jmpGroupDecoder jmpGroupDecoder_inst (
		.phase  (phase),
		.instr  (instr),
		.bundle (jmpBundle)
	);

	opxMultiplexer opxMultiplexer_inst (
		.CLK        (CLK),
		.rstN       (rstN),
		.phase      (phase),
		.instr      (instr),
		.aluBundle  (aluBundle),
		.ldsBundle  (ldsBundle),
		.jmpBundle  (jmpBundle),
		.aluAddrSel (aluAddrSel),
		.ldsAddrSel (ldsAddrSel),
		.ctrl       (ctrl),
		.addrSel    (addrSel)
	);

endmodule

/* hdl/opxMultiplexer.sv */
module opxMultiplexer (
	input  logic              CLK,
	input  logic              rstN,
	input  cpuPkg::cpuPhase   phase,
	input  cpuPkg::instrWord  instr,
	input  cpuPkg::ctrlBundle aluBundle,
	input  cpuPkg::ctrlBundle ldsBundle,
	input  cpuPkg::ctrlBundle jmpBundle,
	input  cpuPkg::addrBusSel aluAddrSel,
	input  cpuPkg::addrBusSel ldsAddrSel,
	output cpuPkg::ctrlBundle ctrl,
	output cpuPkg::addrBusSel addrSel
);

	cpuPkg::instrGroup group;

	assign group = instr[15:14];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// bundle select
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		unique case (group)
			cpuPkg::GroupLoadStore: ctrl = ldsBundle;
			cpuPkg::GroupJump:      ctrl = jmpBundle;
			cpuPkg::GroupAluLogic:  ctrl = aluBundle;
			default:                ctrl = cpuPkg::NopBundle;   // system group.
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// address bus select
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge CLK) begin
		if (!rstN) begin
			addrSel <= cpuPkg::AddrBusPc;
		end else if (phase == cpuPkg::PhaseFetch) begin
			addrSel <= cpuPkg::AddrBusPc;   // pc drives the bus after a fetch.
		end else begin
			unique case (group)
				cpuPkg::GroupLoadStore: addrSel <= ldsAddrSel;
				cpuPkg::GroupAluLogic:  addrSel <= aluAddrSel;
				default:                addrSel <= cpuPkg::AddrBusPc;
			endcase
		end
	end

endmodule

/* hdl/jmpGroupDecoder.sv */
module jmpGroupDecoder (
	input  cpuPkg::cpuPhase   phase,
	input  cpuPkg::instrWord  instr,
	output cpuPkg::ctrlBundle bundle
);

	logic isIndirect;
	logic regActive;

	assign isIndirect = instr[13];
	assign regActive  = (phase == cpuPkg::PhaseDecode) || (phase == cpuPkg::PhaseExecute);

	// target comes from register B or from the immediate.
	always_comb begin
		bundle          = cpuPkg::NopBundle;
		bundle.aluBSrc  = isIndirect ? cpuPkg::AluBSrcRegB : cpuPkg::AluBSrcImm;
		bundle.regBAddr = instr[12:10];
		bundle.regBEn   = regActive;
	end

endmodule

/* hdl/ldsGroupDecoder.sv */
module ldsGroupDecoder (
	input  cpuPkg::cpuPhase   phase,
	input  cpuPkg::instrWord  instr,
	output cpuPkg::ctrlBundle bundle,
	output cpuPkg::addrBusSel addrSel
);

	logic isStore;
	logic isByte;
	logic regActive;
	logic inExecute;
	logic inCommit;

	assign isStore   = instr[13];
	assign isByte    = instr[12];
	assign inExecute = (phase == cpuPkg::PhaseExecute);
	assign inCommit  = (phase == cpuPkg::PhaseCommit);
	assign regActive = (phase == cpuPkg::PhaseDecode) || inExecute;

	always_comb begin
		bundle          = cpuPkg::NopBundle;
		// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
		// address path, base register B through the ALU
		// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
		bundle.aluOp    = cpuPkg::AluOpMovB;
		bundle.aluASrc  = cpuPkg::AluASrcRegA;
		bundle.aluBSrc  = cpuPkg::AluBSrcRegB;
		bundle.regBEn   = regActive;
		bundle.regBWen  = 1'b0;
		bundle.regBAddr = instr[9:7];

		// data path
		bundle.regAEn     = regActive;
		bundle.regAAddr   = instr[11:10];
		bundle.byteMode   = isByte;
		bundle.regAByteEn = isByte ? cpuPkg::ByteEnLow : cpuPkg::ByteEnWord;
		bundle.regBByteEn = cpuPkg::ByteEnWord;
		if (isStore) begin
			bundle.dataBus = cpuPkg::DataBusRegA;
			bundle.regADin = cpuPkg::RegADinAluR;
			bundle.regAWen = 1'b0;
			bundle.wr      = inExecute;
			bundle.rd      = 1'b0;
		end else begin
			bundle.dataBus = cpuPkg::DataBusMem;
			bundle.regADin = cpuPkg::RegADinDataBus;   // load result.
			bundle.regAWen = inCommit;
			bundle.rd      = inExecute;
			bundle.wr      = 1'b0;
		end
	end

	assign addrSel = cpuPkg::AddrBusAluR;

endmodule

/* hdl/aluGroupDecoder.sv */
module aluGroupDecoder (
	input  cpuPkg::cpuPhase   phase,
	input  cpuPkg::instrWord  instr,
	output cpuPkg::ctrlBundle bundle,
	output cpuPkg::addrBusSel addrSel
);

	logic regActive;
	logic regCommit;

	assign regActive = (phase == cpuPkg::PhaseDecode) || (phase == cpuPkg::PhaseExecute);
	assign regCommit = (phase == cpuPkg::PhaseCommit);

	always_comb begin
		bundle            = cpuPkg::NopBundle;
		bundle.aluOp      = instr[13:10];
		bundle.aluASrc    = cpuPkg::AluASrcRegA;
		bundle.aluBSrc    = instr[4] ? cpuPkg::AluBSrcImm : cpuPkg::AluBSrcRegB;
		bundle.dataBus    = cpuPkg::DataBusAluR;
		bundle.regAEn     = regActive;
		bundle.regAWen    = regCommit;   // result goes back to A.
		bundle.regAAddr   = instr[9:8];
		bundle.regADin    = cpuPkg::RegADinAluR;
		bundle.regAByteEn = cpuPkg::ByteEnWord;
		bundle.regBEn     = regActive;
		bundle.regBWen    = 1'b0;
		bundle.regBAddr   = instr[7:5];
		bundle.regBByteEn = cpuPkg::ByteEnWord;
		bundle.byteMode   = 1'b0;
		bundle.rd         = 1'b0;
		bundle.wr         = 1'b0;
	end

	assign addrSel = cpuPkg::AddrBusPc;   // no memory access.

endmodule

/* hdl/phaseSequencer.sv */
module phaseSequencer (
	input  logic             CLK,
	input  logic             rstN,
	input  cpuPkg::instrWord fetchWord,
	output cpuPkg::cpuPhase  phase,
	output cpuPkg::instrWord instr
);

	cpuPkg::cpuPhase phaseNext;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// phase FSM
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		unique case (phase)
			cpuPkg::PhaseFetch:   phaseNext = cpuPkg::PhaseDecode;
			cpuPkg::PhaseDecode:  phaseNext = cpuPkg::PhaseExecute;
			cpuPkg::PhaseExecute: phaseNext = cpuPkg::PhaseCommit;
			default:              phaseNext = cpuPkg::PhaseFetch;   // wrap after commit.
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			phase <= cpuPkg::PhaseFetch;
		end else begin
			phase <= phaseNext;
		end
	end

	// instruction register, loaded on the edge that ends fetch
	always_ff @(posedge CLK) begin
		if (!rstN) begin
			instr <= '0;   // system group.
		end else if (phase == cpuPkg::PhaseFetch) begin
			instr <= fetchWord;
		end
	end

endmodule

/* hdl/cpuPkg.sv */
package cpuPkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// field types
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef logic [15:0] instrWord;
	typedef logic [1:0]  instrGroup;   // bits 15:14.
	typedef logic [3:0]  aluOp;
	typedef logic [2:0]  aluASrc;
	typedef logic [2:0]  aluBSrc;
	typedef logic [1:0]  dataBusSel;
	typedef logic [1:0]  regADinSel;
	typedef logic [1:0]  regAAddr;
	typedef logic [2:0]  regBAddr;
	typedef logic [1:0]  byteEnable;   // one bit per byte lane.
	typedef logic [1:0]  addrBusSel;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// selector codes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam instrGroup GroupSystem    = 2'b00;
	localparam instrGroup GroupLoadStore = 2'b01;
	localparam instrGroup GroupJump      = 2'b10;
	localparam instrGroup GroupAluLogic  = 2'b11;

	localparam aluOp AluOpMov  = 4'h0;   // passes A.
	localparam aluOp AluOpMovB = 4'h1;   // passes B.

	localparam aluASrc AluASrcRegA = 3'd0;

	localparam aluBSrc AluBSrcRegB = 3'd0;
	localparam aluBSrc AluBSrcImm  = 3'd1;

	localparam dataBusSel DataBusAluR = 2'd0;
	localparam dataBusSel DataBusMem  = 2'd1;
	localparam dataBusSel DataBusRegA = 2'd2;   // register A drives the bus.

	localparam regADinSel RegADinAluR    = 2'd0;
	localparam regADinSel RegADinDataBus = 2'd1;

	localparam byteEnable ByteEnWord = 2'b11;
	localparam byteEnable ByteEnLow  = 2'b01;

	localparam addrBusSel AddrBusPc   = 2'd0;
	localparam addrBusSel AddrBusAluR = 2'd1;

	typedef enum logic [1:0] {
		PhaseFetch   = 2'd0,
		PhaseDecode  = 2'd1,
		PhaseExecute = 2'd2,
		PhaseCommit  = 2'd3
	} cpuPhase;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// control bundle
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef struct packed {
		aluOp      aluOp;
		aluASrc    aluASrc;
		aluBSrc    aluBSrc;
		dataBusSel dataBus;
		logic      regAEn;
		logic      regAWen;
		regAAddr   regAAddr;
		regADinSel regADin;
		byteEnable regAByteEn;
		logic      regBEn;
		logic      regBWen;
		regBAddr   regBAddr;
		byteEnable regBByteEn;
		logic      byteMode;
		logic      rd;         // memory read strobe.
		logic      wr;         // memory write strobe.
	} ctrlBundle;

	localparam ctrlBundle NopBundle = '{
		aluOp:      AluOpMov,
		aluASrc:    AluASrcRegA,
		aluBSrc:    AluBSrcRegB,
		dataBus:    DataBusAluR,
		regADin:    RegADinAluR,
		regAByteEn: ByteEnWord,
		regBByteEn: ByteEnWord,
		default:    '0
	};

endpackage
